// ==== hw/apb_sprite_port.sv ====
`timescale 1ns/1ns

module apb_sprite_port (
  input  logic                  clk,
  input  logic                  rst,
  input  tile_pkg::apb_req_t    i_apb,
  output tile_pkg::apb_rsp_t    o_apb,
  output logic                  o_player_we,
  output logic                  o_tile_we,
  output logic [11:0]           o_waddr,
  output tile_pkg::pixel_word_t o_wdata
);

  logic [13:0] word_idx;   // paddr in 32-bit words
  logic        in_player;
  logic        in_tile;
  logic        access;     // APB access phase
  logic        bad_req;
  logic        pslverr_q;

  // ------------------------------
  // Region decode
  // ------------------------------
  always_comb begin
    word_idx  = i_apb.paddr[15:2];
    in_player = word_idx < tile_pkg::PLAYER_RAM_DEPTH;
    in_tile   = (word_idx >= tile_pkg::TILE_REGION_BASE) &&
                (word_idx < tile_pkg::TILE_REGION_BASE + tile_pkg::TILE_RAM_DEPTH);
    access    = i_apb.psel && i_apb.penable;
    bad_req   = !i_apb.pwrite || !(in_player || in_tile);  // Reads are not supported

    o_player_we = access && i_apb.pwrite && in_player;
    o_tile_we   = access && i_apb.pwrite && in_tile;
    o_waddr     = in_tile ? 12'(word_idx - 14'(tile_pkg::TILE_REGION_BASE))
                          : word_idx[11:0];  // Tile sheet starts at zero
    o_wdata.raw = i_apb.pwdata[11:0];
  end

  // Error is decided in the setup phase so it is ready for the access phase
  always_ff @(posedge clk) begin
    if (rst) pslverr_q <= 1'b0;
    else     pslverr_q <= i_apb.psel && !i_apb.penable && bad_req;
  end

  // Zero wait states
  assign o_apb.pready  = 1'b1;
  assign o_apb.pslverr = pslverr_q && access;
  assign o_apb.prdata  = '0;

  a_penable_needs_psel : assert property (
    @(posedge clk) disable iff (rst) i_apb.penable |-> i_apb.psel
  );

endmodule

// ==== hw/map_addr_gen.sv ====
`timescale 1ns/1ns

module map_addr_gen (
  input  logic                            clk,
  input  logic                            rst,
  input  tile_pkg::draw_pos_t             i_draw,
  output tile_pkg::stage_t                o_stage,
  output logic [tile_pkg::MAP_ADDR_W-1:0] o_map_addr
);

  logic                            border;
  logic [8:0]                      map_x;      // Offset into the play field
  logic [7:0]                      map_y;
  logic [4:0]                      col;
  logic [3:0]                      row;
  logic [tile_pkg::MAP_ADDR_W-1:0] addr_next;
  tile_pkg::stage_t                stage_next;

  // ------------------------------
  // Border test and cell lookup
  // ------------------------------
  always_comb begin
    border = (i_draw.x < tile_pkg::BRD_SIDE) ||
             (i_draw.x >= tile_pkg::SCREEN_W - tile_pkg::BRD_SIDE) ||
             (i_draw.y < tile_pkg::BRD_TOP) ||
             (i_draw.y >= tile_pkg::SCREEN_H - tile_pkg::BRD_BOT);

    // Wraps inside the border, result is masked there anyway
    map_x = i_draw.x - 9'(tile_pkg::BRD_SIDE);
    map_y = i_draw.y - 8'(tile_pkg::BRD_TOP);

    col = map_x[8:tile_pkg::BLK_W_LOG2];  // Cells are a power of two wide
    row = map_y[7:tile_pkg::BLK_H_LOG2];

    addr_next = tile_pkg::MAP_ADDR_W'(row * tile_pkg::NUM_COL + col);  // Row major map

    stage_next.valid  = i_draw.valid;
    stage_next.border = border;
    stage_next.cell_x = map_x[tile_pkg::BLK_W_LOG2-1:0];
    stage_next.cell_y = map_y[tile_pkg::BLK_H_LOG2-1:0];
    stage_next.pos    = i_draw;
  end

  // Stage n+1, map address leaves with it
  always_ff @(posedge clk) begin
    if (rst) begin
      o_stage.valid <= 1'b0;
    end else begin
      o_stage    <= stage_next;
      o_map_addr <= border ? '0 : addr_next;
    end
  end

  // Field coordinates must never land past the last map cell
  a_map_addr_range : assert property (
    @(posedge clk) disable iff (rst)
    (o_stage.valid && !o_stage.border) |-> (o_map_addr < tile_pkg::MAP_DEPTH)
  );

endmodule

// ==== hw/pixel_mux.sv ====
`timescale 1ns/1ns

module pixel_mux (
  input  logic                             clk,
  input  logic                             rst,
  input  tile_pkg::stage_t                 i_stage,       // Item at n+1
  input  tile_pkg::map_state_t             i_tile_state,  // Arrives at n+2
  output logic [tile_pkg::TILE_RAM_AW-1:0] o_tile_raddr,
  input  tile_pkg::pixel_word_t            i_tile_data,   // Arrives at n+3
  input  logic                             i_player_hit,
  input  tile_pkg::pixel_word_t            i_player_data,
  output tile_pkg::pixel_out_t             o_pixel
);

  tile_pkg::stage_t      stage_q;    // n+2
  tile_pkg::stage_t      stage_q2;   // n+3
  tile_pkg::map_state_t  state_q;    // Tile state at n+3
  logic [1:0]            tile_frame;
  tile_pkg::pixel_word_t px_next;
  tile_pkg::pixel_word_t px_q;
  logic                  valid_q;

  // ------------------------------
  // Stage delay and tile address
  // ------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      stage_q.valid  <= 1'b0;
      stage_q2.valid <= 1'b0;
    end else begin
      stage_q  <= i_stage;
      stage_q2 <= stage_q;
      state_q  <= i_tile_state;
    end
  end

  always_comb begin
    case (i_tile_state)
      tile_pkg::DEST_BLK: tile_frame = 2'd1;
      tile_pkg::BOMB:     tile_frame = 2'd2;  // Single static bomb frame
      default:            tile_frame = 2'd0;  // Permanent block, empty is don't care
    endcase
    o_tile_raddr = {tile_frame, stage_q.cell_y, stage_q.cell_x};
  end

  // ------------------------------
  // Priority color mux
  // ------------------------------
  always_comb begin
    if (stage_q2.border) begin
      px_next.rgb = tile_pkg::BRD_COLOR;
    end else if (i_player_hit && (i_player_data.raw != tile_pkg::COLOR_KEY)) begin
      px_next = i_player_data;  // Opaque player pixel wins over tiles
    end else begin
      case (state_q)
        tile_pkg::NO_BLK: px_next.rgb = tile_pkg::BG_COLOR;
        tile_pkg::PERM_BLK,
        tile_pkg::DEST_BLK,
        tile_pkg::BOMB: begin
          // Keyed tile pixels show the floor
          if (i_tile_data.raw == tile_pkg::COLOR_KEY) px_next.rgb = tile_pkg::BG_COLOR;
          else px_next = i_tile_data;
        end
        default: px_next.rgb = tile_pkg::ERR_COLOR;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) valid_q <= 1'b0;
    else     valid_q <= stage_q2.valid;
  end

  always_ff @(posedge clk) begin
    px_q <= px_next;
  end

  assign o_pixel.valid = valid_q;  // Pixel for the draw input of n
  assign o_pixel.px    = px_q;

endmodule

// ==== hw/player_sprite.sv ====
`timescale 1ns/1ns

module player_sprite (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               i_tick,
  input  tile_pkg::player_t                  i_player,
  input  tile_pkg::stage_t                   i_stage,
  output logic [tile_pkg::PLAYER_RAM_AW-1:0] o_ram_addr,
  input  tile_pkg::pixel_word_t              i_ram_data,
  output logic                               o_hit,
  output tile_pkg::pixel_word_t              o_data
);

  logic [5:0] tick_cnt;    // 0..59
  logic [1:0] walk_frame;  // 0..2 within a direction row
  logic [8:0] local_x;
  logic [7:0] local_y;
  logic       hit;
  logic       hit_q;       // Lines up with RAM data at n+2
  logic [1:0] dir_row;
  logic [3:0] frame_idx;
  logic [3:0] sheet_x;     // Column after the flip

  // ------------------------------
  // Walk animation
  // ------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      tick_cnt   <= '0;
      walk_frame <= '0;
    end else if (i_tick) begin
      if (tick_cnt == 6'(tile_pkg::TICKS_PER_SECOND - 1)) tick_cnt <= '0;
      else tick_cnt <= tick_cnt + 6'd1;

      // Only moving players animate, a standing one keeps its pose
      if (i_player.dir != tile_pkg::DIR_NONE &&
          ((tick_cnt + 6'd1) % tile_pkg::WALK_ANIM_TIME) == 0) begin
        if (walk_frame == 2'(tile_pkg::WALK_FRAMES_PER_DIR - 1)) walk_frame <= '0;
        else walk_frame <= walk_frame + 2'd1;
      end
    end
  end

  // ------------------------------
  // Bounds, frame select and address
  // ------------------------------
  always_comb begin
    local_x = i_stage.pos.x - i_player.x;
    local_y = i_stage.pos.y - i_player.y;
    hit = i_stage.valid &&
          (i_stage.pos.x >= i_player.x) && (local_x < tile_pkg::SPRITE_W) &&
          (i_stage.pos.y >= i_player.y) && (local_y < tile_pkg::SPRITE_H);

    case (i_player.dir)
      tile_pkg::DIR_LEFT,
      tile_pkg::DIR_RIGHT: dir_row = 2'd1;  // Left reuses the right frames
      tile_pkg::DIR_UP:    dir_row = 2'd2;
      default:             dir_row = 2'd0;  // Down, also used when standing
    endcase

    frame_idx = 4'(dir_row * tile_pkg::WALK_FRAMES_PER_DIR) + 4'(walk_frame);

    // Mirror the right-facing frame
    if (i_player.dir == tile_pkg::DIR_LEFT)
      sheet_x = 4'(tile_pkg::SPRITE_W - 1) - local_x[3:0];
    else
      sheet_x = local_x[3:0];

    o_ram_addr = tile_pkg::PLAYER_RAM_AW'(frame_idx * tile_pkg::SPRITE_SIZE +
                                          local_y[4:0] * tile_pkg::SPRITE_W + sheet_x);
  end

  // Hit flag follows the RAM read, then both land at n+3
  always_ff @(posedge clk) begin
    if (rst) begin
      hit_q <= 1'b0;
      o_hit <= 1'b0;
    end else begin
      hit_q <= hit;
      o_hit <= hit_q;
    end
  end

  always_ff @(posedge clk) begin
    o_data <= i_ram_data;
  end

  a_walk_frame_range : assert property (
    @(posedge clk) disable iff (rst) walk_frame < tile_pkg::WALK_FRAMES_PER_DIR
  );

endmodule

// ==== hw/sprite_ram.sv ====
`timescale 1ns/1ns

module sprite_ram #(
  parameter int DEPTH = 768,
  parameter int AW    = 10
) (
  input  logic                  clk,
  input  logic                  i_we,
  input  logic [AW-1:0]         i_waddr,
  input  tile_pkg::pixel_word_t i_wdata,
  input  logic [AW-1:0]         i_raddr,
  output tile_pkg::pixel_word_t o_rdata
);

  tile_pkg::pixel_word_t mem [DEPTH];  // Sprite sheet, loaded by the host

  // ------------------------------
  // Host write port
  // ------------------------------
  always_ff @(posedge clk) begin
    if (i_we) begin
      mem[i_waddr] <= i_wdata;
    end
  end

  // Pixel read port, one clock latency
  always_ff @(posedge clk) begin
    o_rdata <= mem[i_raddr];
  end

  // The APB decoder must keep strobes inside this sheet
  a_waddr_range : assert property (
    @(posedge clk) i_we |-> (i_waddr < DEPTH)
  );

endmodule

// ==== hw/tile_pkg.sv ====
package tile_pkg;

  // ------------------------------
  // Screen and play field geometry
  // ------------------------------
  localparam int SCREEN_W   = 320;
  localparam int SCREEN_H   = 240;
  localparam int BRD_SIDE   = 8;    // Left and right border
  localparam int BRD_TOP    = 48;   // Room for the status bar
  localparam int BRD_BOT    = 16;
  localparam int BLK_W      = 16;   // Must stay a power of two
  localparam int BLK_H      = 16;
  localparam int BLK_W_LOG2 = 4;
  localparam int BLK_H_LOG2 = 4;
  localparam int NUM_COL    = 19;   // (320 - 2*8) / 16
  localparam int NUM_ROW    = 11;   // (240 - 48 - 16) / 16
  localparam int MAP_DEPTH  = NUM_COL * NUM_ROW;
  localparam int MAP_ADDR_W = 8;

  // ------------------------------
  // Sprite sheet layout
  // ------------------------------
  localparam int SPRITE_W            = 16;
  localparam int SPRITE_H            = 24;
  localparam int SPRITE_SIZE         = SPRITE_W * SPRITE_H;
  localparam int WALK_FRAMES_PER_DIR = 3;
  localparam int WALK_FRAMES_TOTAL   = 3 * WALK_FRAMES_PER_DIR;  // Down, left/right, up
  localparam int WALK_ANIM_TIME      = 10;                       // Ticks per walk frame
  localparam int TICKS_PER_SECOND    = 60;
  localparam int PLAYER_RAM_DEPTH    = WALK_FRAMES_TOTAL * SPRITE_SIZE;  // 3456
  localparam int TILE_FRAMES         = 3;                        // Perm, destroyable, bomb
  localparam int TILE_RAM_DEPTH      = TILE_FRAMES * BLK_W * BLK_H;     // 768
  localparam int PLAYER_RAM_AW       = 12;
  localparam int TILE_RAM_AW         = 10;
  localparam int TILE_REGION_BASE    = 4096;  // Word index of tile RAM in APB space
  localparam int PIPE_LATENCY        = 4;     // Draw input to pixel output

  // Pixel words and colors
  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } rgb_t;

  typedef union packed {
    rgb_t        rgb;  // Channel view for the output
    logic [11:0] raw;  // Whole-word view for the color key test
  } pixel_word_t;

  localparam logic [11:0] COLOR_KEY = 12'hF0F;  // Magenta is transparent
  localparam rgb_t BRD_COLOR = '{r: 4'hF, g: 4'hF, b: 4'hF};
  localparam rgb_t BG_COLOR  = '{r: 4'h1, g: 4'h7, b: 4'h3};
  localparam rgb_t ERR_COLOR = '{r: 4'hF, g: 4'h0, b: 4'hF};

  typedef enum logic [2:0] {DIR_NONE, DIR_DOWN, DIR_LEFT, DIR_RIGHT, DIR_UP} dir_t;
  typedef enum logic [1:0] {NO_BLK, PERM_BLK, DEST_BLK, BOMB} map_state_t;

  // ------------------------------
  // Pipeline and bus bundles
  // ------------------------------
  typedef struct packed {
    logic       valid;
    logic [8:0] x;
    logic [7:0] y;
  } draw_pos_t;

  typedef struct packed {
    logic [8:0] x;  // Top left corner of the sprite
    logic [7:0] y;
    dir_t       dir;
  } player_t;

  typedef struct packed {
    logic        valid;
    pixel_word_t px;
  } pixel_out_t;

  typedef struct packed {
    logic       valid;
    logic       border;
    logic [3:0] cell_x;  // Pixel position inside the map cell
    logic [3:0] cell_y;
    draw_pos_t  pos;
  } stage_t;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [15:0] paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic        pready;
    logic        pslverr;
    logic [31:0] prdata;
  } apb_rsp_t;

endpackage

// ==== hw/tile_renderer_top.sv ====
`timescale 1ns/1ns

module tile_renderer_top (
  input  logic                            clk,
  input  logic                            rst,
  input  tile_pkg::draw_pos_t             i_draw,
  input  tile_pkg::player_t               i_player,
  input  logic                            i_tick,
  input  tile_pkg::map_state_t            i_map_tile_state,
  output logic [tile_pkg::MAP_ADDR_W-1:0] o_map_addr,
  input  tile_pkg::apb_req_t              i_apb,
  output tile_pkg::apb_rsp_t              o_apb,
  output tile_pkg::pixel_out_t            o_pixel
);

  tile_pkg::stage_t                          stage_s1;     // Item at n+1
  logic [tile_pkg::PLAYER_RAM_AW-1:0]        player_raddr;
  tile_pkg::pixel_word_t                     player_rdata;
  logic                                      player_hit;   // Aligned to n+3
  tile_pkg::pixel_word_t                     player_px;
  logic [tile_pkg::TILE_RAM_AW-1:0]          tile_raddr;
  tile_pkg::pixel_word_t                     tile_rdata;
  logic                                      player_we;
  logic                                      tile_we;
  logic [11:0]                               host_waddr;   // Already rebased per region
  tile_pkg::pixel_word_t                     host_wdata;

  // ------------------------------
  // Pixel pipeline
  // ------------------------------
  map_addr_gen i_map_addr_gen (
    .clk        (clk),
    .rst        (rst),
    .i_draw     (i_draw),
    .o_stage    (stage_s1),
    .o_map_addr (o_map_addr)
  );

  player_sprite i_player_sprite (
    .clk        (clk),
    .rst        (rst),
    .i_tick     (i_tick),
    .i_player   (i_player),
    .i_stage    (stage_s1),
    .o_ram_addr (player_raddr),
    .i_ram_data (player_rdata),
    .o_hit      (player_hit),
    .o_data     (player_px)
  );

  pixel_mux i_pixel_mux (
    .clk           (clk),
    .rst           (rst),
    .i_stage       (stage_s1),
    .i_tile_state  (i_map_tile_state),  // Map memory answers at n+2
    .o_tile_raddr  (tile_raddr),
    .i_tile_data   (tile_rdata),
    .i_player_hit  (player_hit),
    .i_player_data (player_px),
    .o_pixel       (o_pixel)
  );

  // ------------------------------
  // Host port and sprite sheets
  // ------------------------------
  apb_sprite_port i_apb_sprite_port (
    .clk         (clk),
    .rst         (rst),
    .i_apb       (i_apb),
    .o_apb       (o_apb),
    .o_player_we (player_we),
    .o_tile_we   (tile_we),
    .o_waddr     (host_waddr),
    .o_wdata     (host_wdata)
  );

  sprite_ram #(
    .DEPTH (tile_pkg::PLAYER_RAM_DEPTH),
    .AW    (tile_pkg::PLAYER_RAM_AW)
  ) i_player_ram (
    .clk     (clk),
    .i_we    (player_we),
    .i_waddr (host_waddr),
    .i_wdata (host_wdata),
    .i_raddr (player_raddr),
    .o_rdata (player_rdata)
  );

  sprite_ram #(
    .DEPTH (tile_pkg::TILE_RAM_DEPTH),
    .AW    (tile_pkg::TILE_RAM_AW)
  ) i_tile_ram (
    .clk     (clk),
    .i_we    (tile_we),
    .i_waddr (host_waddr[tile_pkg::TILE_RAM_AW-1:0]),  // Tile offsets fit in 10 bits
    .i_wdata (host_wdata),
    .i_raddr (tile_raddr),
    .o_rdata (tile_rdata)
  );

endmodule

// ==== sim/tb_tile_renderer.sv ====
`timescale 1ns/1ns

module tb_tile_renderer;

  localparam int WAIT_LIMIT = 16;  // Cycles before any wait gives up
  localparam int SHEET_WORDS = tile_pkg::SPRITE_W * tile_pkg::SPRITE_H;
  localparam int TILE_WORDS  = tile_pkg::BLK_W * tile_pkg::BLK_H;

  logic                            clk;
  logic                            rst;
  tile_pkg::draw_pos_t             draw;
  tile_pkg::player_t               player;
  logic                            tick;
  tile_pkg::map_state_t            tile_state;
  logic [tile_pkg::MAP_ADDR_W-1:0] map_addr;
  tile_pkg::apb_req_t              apb_req;
  tile_pkg::apb_rsp_t              apb_rsp;
  tile_pkg::pixel_out_t            pixel;

  tile_pkg::map_state_t            map_mem [tile_pkg::MAP_DEPTH];  // External map memory
  logic [11:0]                     player_copy [tile_pkg::PLAYER_RAM_DEPTH];
  logic [11:0]                     tile_copy [tile_pkg::TILE_RAM_DEPTH];
  logic [tile_pkg::MAP_ADDR_W-1:0] addr_seen;   // Address of the previous clock
  logic [31:0]                     rng;
  int                              errors;
  int                              checks;
  int                              tick_cnt_m;  // Expected tick counter
  int                              walk_m;      // Expected walk frame

  tile_renderer_top i_tile_renderer_top (
    .clk              (clk),
    .rst              (rst),
    .i_draw           (draw),
    .i_player         (player),
    .i_tick           (tick),
    .i_map_tile_state (tile_state),
    .o_map_addr       (map_addr),
    .i_apb            (apb_req),
    .o_apb            (apb_rsp),
    .o_pixel          (pixel)
  );

  always #10 clk = ~clk;  // 20 ns period

  // Map memory answers one clock after the address
  always @(posedge clk) begin
    #2;
    tile_state = map_mem[addr_seen];
    addr_seen  = map_addr;
  end

  // ------------------------------
  // Helpers and reference model
  // ------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] v;
    v = s ^ (s << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  task automatic step();
    @(posedge clk);
    #2;  // Inputs change just after the edge
  endtask

  function automatic logic in_border(input int x, input int y);
    return (x < tile_pkg::BRD_SIDE) || (x >= tile_pkg::SCREEN_W - tile_pkg::BRD_SIDE) ||
           (y < tile_pkg::BRD_TOP) || (y >= tile_pkg::SCREEN_H - tile_pkg::BRD_BOT);
  endfunction

  function automatic int map_cell(input int x, input int y);
    if (in_border(x, y)) return 0;  // Border drives address zero
    return ((y - tile_pkg::BRD_TOP) / tile_pkg::BLK_H) * tile_pkg::NUM_COL +
           (x - tile_pkg::BRD_SIDE) / tile_pkg::BLK_W;
  endfunction

  function automatic logic [11:0] model_pixel(input int x, input int y);
    int lx;
    int ly;
    int row;
    int col;
    logic [11:0] word;
    tile_pkg::map_state_t st;
    lx = x - int'(player.x);
    ly = y - int'(player.y);
    if (in_border(x, y)) return tile_pkg::BRD_COLOR;
    if (lx >= 0 && lx < tile_pkg::SPRITE_W && ly >= 0 && ly < tile_pkg::SPRITE_H) begin
      case (player.dir)
        tile_pkg::DIR_LEFT, tile_pkg::DIR_RIGHT: row = 1;
        tile_pkg::DIR_UP: row = 2;
        default: row = 0;                     // Down, also when standing
      endcase
      col = (player.dir == tile_pkg::DIR_LEFT) ? tile_pkg::SPRITE_W - 1 - lx : lx;
      word = player_copy[(row * tile_pkg::WALK_FRAMES_PER_DIR + walk_m) * SHEET_WORDS +
                         ly * tile_pkg::SPRITE_W + col];
      if (word != tile_pkg::COLOR_KEY) return word;  // Opaque player pixel
    end
    st = map_mem[map_cell(x, y)];
    if (st == tile_pkg::NO_BLK) return tile_pkg::BG_COLOR;
    word = tile_copy[(int'(st) - 1) * TILE_WORDS +
                     ((y - tile_pkg::BRD_TOP) % tile_pkg::BLK_H) * tile_pkg::BLK_W +
                     (x - tile_pkg::BRD_SIDE) % tile_pkg::BLK_W];
    if (word == tile_pkg::COLOR_KEY) return tile_pkg::BG_COLOR;
    return word;
  endfunction

  // ------------------------------
  // APB driver
  // ------------------------------
  task automatic apb_access(input logic wr, input int word, input logic [11:0] data,
                            input logic exp_err);
    int wait_cnt;
    logic done;
    logic got_err;
    logic [31:0] got_rdata;
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: 16'(word * 4),
                pwdata: {20'hA5A5A, data}};  // Upper bits are ignored
    step();
    apb_req.penable = 1'b1;
    done = 1'b0;
    got_err = 1'b0;
    got_rdata = '0;
    wait_cnt = 0;
    while (!done && wait_cnt < WAIT_LIMIT) begin
      #5;  // Mid cycle sample
      done      = apb_rsp.pready;
      got_err   = apb_rsp.pslverr;
      got_rdata = apb_rsp.prdata;
      step();
      wait_cnt++;
    end
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
    checks++;
    if (!done) begin
      $display("APB transfer at word %0d never saw pready", word);
      errors++;
    end else begin
      if (got_err !== exp_err) begin
        $display("** Error at %0t: o_apb.pslverr expected %b, got %b (word %0d)",
                 $time, exp_err, got_err, word);
        errors++;
      end
      if (got_rdata !== 32'h0) begin  // No read data path at all
        $display("** Error at %0t: o_apb.prdata expected 0, got %h (word %0d)",
                 $time, got_rdata, word);
        errors++;
      end
    end
  endtask

  task automatic apb_write(input int word, input logic [11:0] data);
    apb_access(1'b1, word, data, 1'b0);
  endtask

  task automatic load_sheets();
    for (int i = 0; i < tile_pkg::PLAYER_RAM_DEPTH; i++) begin
      rng = xorshift32(rng);
      player_copy[i] = rng[11:0];
    end
    for (int i = 0; i < tile_pkg::TILE_RAM_DEPTH; i++) begin
      rng = xorshift32(rng);
      tile_copy[i] = rng[11:0];
    end
    player_copy[2 * tile_pkg::SPRITE_W + 4] = tile_pkg::COLOR_KEY;    // Down frame 0
    player_copy[3 * SHEET_WORDS + tile_pkg::SPRITE_W + 2] = tile_pkg::COLOR_KEY;  // Side row 1
    tile_copy[TILE_WORDS + 3 * tile_pkg::BLK_W + 5] = tile_pkg::COLOR_KEY;  // Destroyable
    for (int i = 0; i < tile_pkg::PLAYER_RAM_DEPTH; i++) apb_write(i, player_copy[i]);
    for (int i = 0; i < tile_pkg::TILE_RAM_DEPTH; i++) begin
      apb_write(tile_pkg::TILE_REGION_BASE + i, tile_copy[i]);
    end
  endtask

  // ------------------------------
  // Pixel checks
  // ------------------------------
  task automatic check_pixel(input int x, input int y);
    logic [11:0] exp_px;
    int exp_addr;
    int wait_cnt;
    exp_px   = model_pixel(x, y);
    exp_addr = map_cell(x, y);
    draw = '{valid: 1'b1, x: 9'(x), y: 8'(y)};
    step();
    draw.valid = 1'b0;
    checks++;
    if (map_addr !== tile_pkg::MAP_ADDR_W'(exp_addr)) begin
      $display("** Error at %0t: o_map_addr expected %0d, got %0d (x=%0d y=%0d)",
               $time, exp_addr, map_addr, x, y);
      errors++;
    end
    wait_cnt = 1;
    while (pixel.valid !== 1'b1 && wait_cnt < WAIT_LIMIT) begin
      step();
      wait_cnt++;
    end
    if (pixel.valid !== 1'b1) begin
      $display("No valid pixel came out for x=%0d y=%0d", x, y);
      errors++;
    end else if (wait_cnt != tile_pkg::PIPE_LATENCY) begin
      $display("Pixel for x=%0d y=%0d took %0d clocks", x, y, wait_cnt);
      errors++;
    end else if (pixel.px.raw !== exp_px) begin
      $display("** Error at %0t: o_pixel.px expected %h, got %h (x=%0d y=%0d)",
               $time, exp_px, pixel.px.raw, x, y);
      errors++;
    end
  endtask

  task automatic check_border();
    for (int k = 0; k < 4; k++) begin
      rng = xorshift32(rng);
      check_pixel((k < 2) ? k * 7 : 312 + (k - 2) * 7, 48 + int'(rng[15:0] % 176));
      check_pixel(8 + int'(rng[31:16] % 304), (k < 2) ? k * 47 : 224 + (k - 2) * 15);
    end
  endtask

  // Whole sprite box plus a one pixel margin
  task automatic check_sprite_area();
    for (int y = int'(player.y) - 1; y <= int'(player.y) + tile_pkg::SPRITE_H; y++) begin
      for (int x = int'(player.x) - 1; x <= int'(player.x) + tile_pkg::SPRITE_W; x++) begin
        check_pixel(x, y);
      end
    end
  endtask

  task automatic pulse_ticks(input int count);
    for (int i = 0; i < count; i++) begin
      tick = 1'b1;
      step();
      tick = 1'b0;
      tick_cnt_m = (tick_cnt_m + 1) % tile_pkg::TICKS_PER_SECOND;
      if (player.dir != tile_pkg::DIR_NONE && tick_cnt_m % tile_pkg::WALK_ANIM_TIME == 0)
        walk_m = (walk_m + 1) % tile_pkg::WALK_FRAMES_PER_DIR;
    end
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------
  task automatic reset_outputs();
    for (int i = 0; i < 8; i++) begin
      step();
      checks++;
      if (pixel.valid !== 1'b0) begin
        $display("** Error at %0t: o_pixel.valid expected 0, got %b", $time, pixel.valid);
        errors++;
      end
      if (apb_rsp.pslverr !== 1'b0) begin
        $display("** Error at %0t: o_apb.pslverr expected 0, got %b",
                 $time, apb_rsp.pslverr);
        errors++;
      end
    end
    rst = 1'b0;
    step();
  endtask

  // Player word 0 shows in the overlay, word 904 in the standing frame 2
  task automatic rejected_accesses();
    apb_access(1'b1, 5000, 12'h0F0, 1'b1);
    apb_access(1'b0, 0, 12'hABC, 1'b1);
    apb_access(1'b0, tile_pkg::TILE_REGION_BASE + 1, 12'h123, 1'b1);
    apb_access(1'b0, 5000, 12'h456, 1'b1);
    map_mem[0] = tile_pkg::PERM_BLK;
    check_pixel(tile_pkg::BRD_SIDE + 1, tile_pkg::BRD_TOP);  // Tile word 1
  endtask

  task automatic fill_map();
    for (int i = 0; i < tile_pkg::MAP_DEPTH; i++) begin
      rng = xorshift32(rng);
      map_mem[i] = tile_pkg::map_state_t'(rng[1:0]);
    end
  endtask

  task automatic random_field();
    for (int i = 0; i < 300; i++) begin
      rng = xorshift32(rng);
      check_pixel(8 + int'(rng[15:0] % 304), 48 + int'(rng[31:16] % 176));
    end
  endtask

  task automatic tile_states();
    for (int s = 0; s < 4; s++) begin
      map_mem[s] = tile_pkg::map_state_t'(s);
      check_pixel(8 + s * 16 + 7, 48 + 9);
    end
    map_mem[tile_pkg::NUM_COL + 2] = tile_pkg::DEST_BLK;
    check_pixel(8 + 32 + 5, 48 + 16 + 3);  // Keyed tile word
  endtask

  // Down then mirrored left
  task automatic player_overlay();
    player = '{x: 9'd100, y: 8'd100, dir: tile_pkg::DIR_DOWN};
    check_sprite_area();
    player.dir = tile_pkg::DIR_LEFT;
    check_sprite_area();
  endtask

  task automatic walk_animation();
    player.dir = tile_pkg::DIR_RIGHT;
    pulse_ticks(10);
    check_sprite_area();
    pulse_ticks(20);
    check_sprite_area();                    // Frame 0 again
    pulse_ticks(20);
    player.dir = tile_pkg::DIR_NONE;
    pulse_ticks(15);                        // Tick counter wraps here
    check_sprite_area();                    // Down row, frame 2 held
    player.dir = tile_pkg::DIR_UP;
    pulse_ticks(5);
    check_sprite_area();
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    draw = '0;
    player = '{x: 9'd330, y: 8'd0, dir: tile_pkg::DIR_NONE};  // Off screen
    tick = 1'b0;
    tile_state = tile_pkg::NO_BLK;
    apb_req = '0;
    addr_seen = '0;
    rng = 32'hef3c;
    errors = 0;
    checks = 0;
    tick_cnt_m = 0;
    walk_m = 0;
    for (int i = 0; i < tile_pkg::MAP_DEPTH; i++) map_mem[i] = tile_pkg::NO_BLK;

    reset_outputs();
    load_sheets();
    rejected_accesses();
    fill_map();
    check_border();
    random_field();
    tile_states();
    player_overlay();
    walk_animation();

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
hw/tile_pkg.sv
hw/map_addr_gen.sv
hw/player_sprite.sv
hw/sprite_ram.sv
hw/apb_sprite_port.sv
hw/pixel_mux.sv
hw/tile_renderer_top.sv
sim/tb_tile_renderer.sv
